/* project.f */
hdl/snappy_pkg.sv
hdl/lead_zero_count.sv
hdl/tag_decode.sv
hdl/token_cutter.sv
hdl/desc_fifo.sv
hdl/token_parser.sv
bench/token_checker.sv
bench/tb_token_parser.sv

/* bench/tb_token_parser.sv */
// testbench for the snappy token parser
// random legal streams always end on a slice boundary, tag 11 is never used
// expected descriptors come from walking the stream tag by tag
// output addresses run on across tests since reset is applied once
`timescale 1ns/100ps

module tb_token_parser;

	import snappy_pkg::*;

	localparam int MAX_BYTES   = 40 * SLICE_BYTES;
	localparam int CYCLE_LIMIT = 40 * (6 + 6 + 40 + 40) + 200;  // all slices of all tests

	logic        clk;
	logic        rst_n;
	slice_t      slice_i;
	logic        slice_valid_i;
	logic        slice_ready_o;
	lit_desc_t   lit_desc_o;
	logic        lit_valid_o;
	logic        lit_ready_i;
	copy_desc_t  copy_desc_o;
	logic        copy_valid_o;
	logic        copy_ready_i;
	logic        all_empty_o;

	logic [7:0]  strm [MAX_BYTES];
	bit          tok_start [MAX_BYTES];
	bit          lit_body [MAX_BYTES];  // byte lies inside a literal body
	int          nbytes;
	logic [15:0] ref_addr = '0;
	int          seed = 46;
	bit          rand_ready = 1'b0;
	int          cycles = 0;
	int          tb_errors = 0;
	int          tests_pass = 0;
	int          tests_fail = 0;

	token_parser #(.LIT_DEPTH(8), .COPY_DEPTH(8)) u_dut (.*);

	token_checker u_chk (
		.clk          (clk),
		.rst_n        (rst_n),
		.lit_desc_i   (lit_desc_o),
		.lit_valid_i  (lit_valid_o),
		.lit_ready_i  (lit_ready_i),
		.copy_desc_i  (copy_desc_o),
		.copy_valid_i (copy_valid_o),
		.copy_ready_i (copy_ready_i)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run did not complete within %0d cycles", CYCLE_LIMIT);
			$display("Simulation failed");
			$finish;
		end
	end

	function automatic int rand_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	// output ready is random only during the back-pressure test
	initial begin
		lit_ready_i  = 1'b1;
		copy_ready_i = 1'b1;
		forever begin
			@(negedge clk);
			lit_ready_i  = rand_ready ? (rand_below(2) == 1) : 1'b1;
			copy_ready_i = rand_ready ? (rand_below(2) == 1) : 1'b1;
		end
	end

	function automatic void put_byte(input logic [7:0] b, input bit start, input bit body);
		strm[nbytes]      = b;
		tok_start[nbytes] = start;
		lit_body[nbytes]  = body;
		nbytes++;
	endfunction

	function automatic void put_literal(input int len);
		put_byte({6'(len - 1), 2'b00}, 1'b1, 1'b0);
		for (int i = 0; i < len; i++)
			put_byte(8'(rand_below(256)), 1'b0, 1'b1);
	endfunction

	function automatic void put_copy(input bit two);
		if (two)
			put_byte({6'(rand_below(64)), 2'b10}, 1'b1, 1'b0);
		else
			put_byte({3'(rand_below(8)), 3'(rand_below(8)), 2'b01}, 1'b1, 1'b0);
		put_byte(8'(rand_below(256)), 1'b0, 1'b0);
		if (two)
			put_byte(8'(rand_below(256)), 1'b0, 1'b0);
	endfunction

	// mix 0 literals only, 1 copies only, 2 all three token forms
	function automatic void gen_stream(input int nslices, input int mix);
		int total;
		int pick;
		int len;
		total  = nslices * SLICE_BYTES;
		nbytes = 0;
		while (nbytes < total - 64) begin
			pick = (mix == 2) ? rand_below(3) : ((mix == 0) ? 0 : 1 + rand_below(2));
			if (pick == 0)
				put_literal(1 + rand_below(60));
			else
				put_copy(pick == 2);
		end
		while (nbytes < total) begin
			len = total - nbytes;
			len = (len >= 63) ? 60 : ((len == 62) ? 58 : len - 1);  // never leave one byte
			put_literal(len);
		end
	endfunction

	function automatic slice_t make_slice(input int k);
		slice_t s;
		int     p;
		s = '0;
		for (int i = 0; i < BUF_BYTES; i++) begin
			p = k * SLICE_BYTES + i;
			if (p < nbytes)
				s.data[BUF_BYTES-1-i] = strm[p];  // lookahead past the end stays zero
		end
		for (int i = 0; i < SLICE_BYTES; i++)
			s.token_mask[SLICE_BYTES-1-i] = tok_start[k*SLICE_BYTES+i];
		s.start_lit = lit_body[k * SLICE_BYTES];
		return s;
	endfunction

	// reference model of the whole stream
	function automatic void build_expected();
		int         pos;
		int         len;
		int         seg;
		logic [7:0] tag;
		lit_desc_t  ld;
		copy_desc_t cd;
		pos = 0;
		while (pos < nbytes) begin
			tag = strm[pos];
			if (tag[1:0] == 2'b00) begin
				len = tag[7:2] + 1;
				pos++;
				while (len > 0) begin  // one fragment per slice the body touches
					seg = SLICE_BYTES - pos % SLICE_BYTES;
					if (seg > len)
						seg = len;
					ld       = '0;
					ld.addr  = ref_addr;
					ld.count = 5'(seg);
					for (int i = 0; i < seg; i++)
						ld.bytes[SLICE_BYTES-1-i] = strm[pos+i];
					u_chk.expect_lit(ld);
					ref_addr += 16'(seg);
					pos      += seg;
					len      -= seg;
				end
			end else begin
				len     = (tag[1:0] == 2'b01) ? 4 + tag[4:2] : tag[7:2] + 1;
				cd.addr = ref_addr;
				if (tag[1:0] == 2'b01)
					cd.offset = {5'd0, tag[7:5], strm[pos+1]};
				else
					cd.offset = {strm[pos+2], strm[pos+1]};  // low byte first in the stream
				cd.length = 6'(len);                        // 64 shows as 0
				u_chk.expect_copy(cd);
				ref_addr += 16'(len);
				pos      += (tag[1:0] == 2'b01) ? 2 : 3;
			end
		end
	endfunction

	task automatic send_slice(input slice_t s);
		@(negedge clk);
		slice_i       = s;
		slice_valid_i = 1'b1;
		while (slice_ready_o !== 1'b1)
			@(negedge clk);
		@(negedge clk);  // taken on the edge just passed
		slice_valid_i = 1'b0;
	endtask

	task automatic wait_drained();
		repeat (2) @(negedge clk);  // all_empty_o lags by one register
		while (u_chk.pending() != 0 || all_empty_o !== 1'b1)
			@(negedge clk);
	endtask

	function automatic void close_test(input string name, input int err0);
		int errs;
		errs = tb_errors + u_chk.errors - err0;
		if (errs == 0) begin
			tests_pass++;
			$display("test %-28s ok", name);
		end else begin
			tests_fail++;
			$display("test %-28s %0d errors", name, errs);
		end
	endfunction

	// a negative mix replays the stream already in memory
	task automatic run_stream(input string name, input int nslices, input int mix);
		int err0;
		err0 = tb_errors + u_chk.errors;
		if (mix >= 0)
			gen_stream(nslices, mix);
		build_expected();
		for (int k = 0; k < nslices; k++)
			send_slice(make_slice(k));
		wait_drained();
		close_test(name, err0);
	endtask

	initial begin
		int err0;
		rst_n         = 1'b0;
		slice_i       = '0;
		slice_valid_i = 1'b0;
		repeat (5) begin
			@(negedge clk);
			if (slice_ready_o !== 1'b0 || lit_valid_o !== 1'b0 || copy_valid_o !== 1'b0) begin
				tb_errors++;
				$display("FAIL @%0t: handshake output high during reset", $time);
			end
		end
		rst_n = 1'b1;
		while (all_empty_o !== 1'b1)
			@(negedge clk);
		close_test("reset and idle", 0);

		run_stream("literals only", 6, 0);
		run_stream("copies with lookahead", 6, 1);
		run_stream("mixed stream", 40, 2);
		rand_ready = 1'b1;
		run_stream("mixed with back-pressure", 40, -1);
		rand_ready = 1'b0;

		err0 = tb_errors + u_chk.errors;
		repeat (50) begin
			@(negedge clk);
			if (all_empty_o !== 1'b1 || lit_valid_o !== 1'b0 || copy_valid_o !== 1'b0) begin
				tb_errors++;
				$display("FAIL @%0t: output activity after the stream drained", $time);
			end
		end
		u_chk.report_leftovers();
		close_test("drain and quiet", err0);

		$display("tests passed %0d, failed %0d", tests_pass, tests_fail);
		if (tests_fail == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* bench/token_checker.sv */
// watches both descriptor outputs of the token parser
// expected descriptors are queued by the testbench in stream order
// a waiting descriptor must hold valid and its value until ready
`timescale 1ns/100ps

module token_checker (
	input  logic                   clk,
	input  logic                   rst_n,
	input  snappy_pkg::lit_desc_t  lit_desc_i,
	input  logic                   lit_valid_i,
	input  logic                   lit_ready_i,
	input  snappy_pkg::copy_desc_t copy_desc_i,
	input  logic                   copy_valid_i,
	input  logic                   copy_ready_i
);

	import snappy_pkg::*;

	lit_desc_t  exp_lit[$];
	copy_desc_t exp_copy[$];
	lit_desc_t  held_lit;
	copy_desc_t held_copy;
	logic       lit_hold;   // literal output was refused on the last edge
	logic       copy_hold;
	int         errors = 0;

	function automatic void expect_lit(input lit_desc_t d);
		exp_lit.push_back(d);
	endfunction

	function automatic void expect_copy(input copy_desc_t d);
		exp_copy.push_back(d);
	endfunction

	function automatic int pending();
		return exp_lit.size() + exp_copy.size();
	endfunction

	function automatic void report_error(input string msg);
		errors++;
		$display("FAIL @%0t: %s", $time, msg);
	endfunction

	function automatic void report_leftovers();
		if (pending() != 0) begin
			errors++;
			$display("%0d literal and %0d copy descriptors were expected but never came out",
				exp_lit.size(), exp_copy.size());
		end
	endfunction

	function automatic void check_lit(input lit_desc_t got);
		lit_desc_t want;
		if (exp_lit.size() == 0) begin
			errors++;
			$display("extra literal descriptor at %0t for address %0d", $time, got.addr);
		end else begin
			want = exp_lit.pop_front();
			if (got !== want)
				report_error($sformatf("literal addr %0d count %0d bytes %h, expected %0d %0d %h",
					got.addr, got.count, got.bytes, want.addr, want.count, want.bytes));
		end
	endfunction

	function automatic void check_copy(input copy_desc_t got);
		copy_desc_t want;
		if (exp_copy.size() == 0) begin
			errors++;
			$display("extra copy descriptor at %0t for address %0d", $time, got.addr);
		end else begin
			want = exp_copy.pop_front();
			if (got !== want)
				report_error($sformatf("copy addr %0d offset %0d length %0d, expected %0d %0d %0d",
					got.addr, got.offset, got.length, want.addr, want.offset, want.length));
		end
	endfunction

	// values read here are the ones present before the edge
	always @(posedge clk) begin
		if (!rst_n) begin
			lit_hold  <= 1'b0;
			copy_hold <= 1'b0;
		end else begin
			if (lit_hold && (lit_valid_i !== 1'b1 || lit_desc_i !== held_lit))
				report_error("literal output changed while waiting for ready");
			if (copy_hold && (copy_valid_i !== 1'b1 || copy_desc_i !== held_copy))
				report_error("copy output changed while waiting for ready");
			lit_hold  <= lit_valid_i & ~lit_ready_i;
			copy_hold <= copy_valid_i & ~copy_ready_i;
			held_lit  <= lit_desc_i;
			held_copy <= copy_desc_i;
			if (lit_valid_i && lit_ready_i)
				check_lit(lit_desc_i);
			if (copy_valid_i && copy_ready_i)
				check_copy(copy_desc_i);
		end
	end

endmodule

/* hdl/token_parser.sv */
// snappy token parser top level
// one 16-byte slice in, literal and copy descriptors out on two queues
// LIT_DEPTH and COPY_DEPTH must be powers of two, at least 4
// output addresses restart at zero only on reset
`timescale 1ns/100ps

module token_parser #(
	parameter int LIT_DEPTH  = 8,
	parameter int COPY_DEPTH = 8
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  snappy_pkg::slice_t     slice_i,
	input  logic                   slice_valid_i,
	output logic                   slice_ready_o,
	output snappy_pkg::lit_desc_t  lit_desc_o,
	output logic                   lit_valid_o,
	input  logic                   lit_ready_i,
	output snappy_pkg::copy_desc_t copy_desc_o,
	output logic                   copy_valid_o,
	input  logic                   copy_ready_i,
	output logic                   all_empty_o
);

	import snappy_pkg::*;

	lit_desc_t  lit_desc;
	logic       lit_push;
	copy_desc_t copy_desc;
	logic       copy_push;
	logic       stall;
	logic       lit_af;
	logic       copy_af;
	logic       lit_empty;
	logic       copy_empty;
	logic       cut_idle;

	token_cutter u_cutter (
		.clk           (clk),
		.rst_n         (rst_n),
		.slice_i       (slice_i),
		.slice_valid_i (slice_valid_i),
		.slice_ready_o (slice_ready_o),
		.stall_i       (stall),
		.lit_desc_o    (lit_desc),
		.lit_push_o    (lit_push),
		.copy_desc_o   (copy_desc),
		.copy_push_o   (copy_push),
		.idle_o        (cut_idle)
	);

	desc_fifo #(
		.DEPTH   (LIT_DEPTH),
		.entry_t (lit_desc_t)
	) u_lit_q (
		.clk           (clk),
		.rst_n         (rst_n),
		.push_i        (lit_push),
		.din_i         (lit_desc),
		.almost_full_o (lit_af),
		.empty_o       (lit_empty),
		.valid_o       (lit_valid_o),
		.dout_o        (lit_desc_o),
		.ready_i       (lit_ready_i)
	);

	desc_fifo #(
		.DEPTH   (COPY_DEPTH),
		.entry_t (copy_desc_t)
	) u_copy_q (
		.clk           (clk),
		.rst_n         (rst_n),
		.push_i        (copy_push),
		.din_i         (copy_desc),
		.almost_full_o (copy_af),
		.empty_o       (copy_empty),
		.valid_o       (copy_valid_o),
		.dout_o        (copy_desc_o),
		.ready_i       (copy_ready_i)
	);

	// either queue nearly full holds the cutter
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			stall       <= 1'b0;
			all_empty_o <= 1'b0;
		end else begin
			stall       <= lit_af | copy_af;
			all_empty_o <= lit_empty & copy_empty & cut_idle;  // drained and waiting
		end
	end

endmodule

/* hdl/desc_fifo.sv */
// show-ahead descriptor queue with a registered output stage
// DEPTH must be a power of two, at least 4
// almost_full_o rises with two or fewer free memory slots
// a push into an empty queue reaches valid_o one cycle later
`timescale 1ns/100ps

module desc_fifo #(
	parameter int  DEPTH   = 8,
	parameter type entry_t = logic
) (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   push_i,
	input  entry_t din_i,
	output logic   almost_full_o,
	output logic   empty_o,
	output logic   valid_o,
	output entry_t dout_o,
	input  logic   ready_i
);

	localparam int AW = $clog2(DEPTH);

	entry_t        mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;     // entries held in mem, output stage excluded
	logic          load;
	logic          from_mem;
	logic          bypass;
	logic          mem_wr;

	assign load     = ~valid_o | ready_i;  // output stage free or leaving
	assign from_mem = load & (count != '0);
	assign bypass   = load & (count == '0) & push_i;
	assign mem_wr   = push_i & ~bypass;

	assign almost_full_o = (count >= (AW+1)'(DEPTH - 2));
	assign empty_o       = (count == '0) & ~valid_o;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count   <= '0;
			valid_o <= 1'b0;
		end else begin
			if (mem_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (from_mem)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + (AW+1)'(mem_wr) - (AW+1)'(from_mem);
			if (load)
				valid_o <= from_mem | push_i;
		end
	end

	always_ff @(posedge clk) begin
		if (mem_wr)
			mem[wr_ptr] <= din_i;
		if (from_mem)
			dout_o <= mem[rd_ptr];
		else if (bypass)
			dout_o <= din_i;
	end

endmodule

/* hdl/token_cutter.sv */
// walks the token starts of one slice and issues one descriptor per cycle
// descriptors are registered so pushes trail the cut cycle by one clock
// unmarked leading bytes of a slice are dropped while it is loaded
// a 64-byte copy advances the address by 64 but reports length 0
// stall_i freezes the walk so no descriptor is ever dropped
`timescale 1ns/100ps

module token_cutter (
	input  logic                   clk,
	input  logic                   rst_n,
	input  snappy_pkg::slice_t     slice_i,
	input  logic                   slice_valid_i,
	output logic                   slice_ready_o,
	input  logic                   stall_i,
	output snappy_pkg::lit_desc_t  lit_desc_o,
	output logic                   lit_push_o,
	output snappy_pkg::copy_desc_t copy_desc_o,
	output logic                   copy_push_o,
	output logic                   idle_o
);

	import snappy_pkg::*;

	typedef enum logic [1:0] {S_IDLE, S_WAIT, S_CUT} state_e;

	state_e                      state;
	logic [BUF_BYTES-1:0][7:0]   buf_data;  // head byte in the top lane
	logic [SLICE_BYTES-1:0]      buf_mask;
	logic [4:0]                  buf_rem;   // slice bytes left from the head
	logic                        lit_mode;  // head is a literal body byte
	logic [ADDR_W-1:0]           out_addr;

	logic [BUF_BYTES-1:0][7:0]   src_data;
	logic [SLICE_BYTES-1:0]      src_mask;
	logic [4:0]                  src_rem;
	logic [BUF_BYTES-1:0][7:0]   shift_data;
	logic [SLICE_BYTES-1:0]      shift_mask;
	logic                        lzc_any;
	logic [3:0]                  lzc_zeros;
	logic [4:0]                  next_dist;
	logic                        keep_head;
	logic [4:0]                  shamt;
	logic                        cut_go;
	logic                        head_ok;
	logic                        done;

	tag_u                        head_tag;
	tok_kind_e                   kind;
	logic [1:0]                  hdr_bytes;
	logic [5:0]                  lit_len;
	logic [5:0]                  copy_len;
	logic [15:0]                 copy_off;
	logic [6:0]                  copy_adv;

	logic [1:0]                  body_off;
	logic [BUF_BYTES-1:0][7:0]   body_shift;
	logic [SLICE_BYTES-1:0][7:0] lit_src;
	logic [SLICE_BYTES-1:0][7:0] lit_bytes;
	logic [4:0]                  avail;
	logic [4:0]                  lit_cnt;
	logic                        emit_lit;
	logic                        emit_copy;

	// while waiting the distance logic looks at the incoming slice
	always_comb begin
		if (state == S_WAIT) begin
			src_data = slice_i.data;
			src_mask = slice_i.token_mask;
			src_rem  = 5'(SLICE_BYTES);
		end else begin
			src_data = buf_data;
			src_mask = buf_mask;
			src_rem  = buf_rem;
		end
	end

	lead_zero_count u_lzc (
		.mask_i  ({1'b0, src_mask[SLICE_BYTES-2:0]}),
		.any_o   (lzc_any),
		.zeros_o (lzc_zeros)
	);

	assign next_dist = lzc_any ? {1'b0, lzc_zeros} : src_rem;
	assign keep_head = (state == S_WAIT) ? (slice_i.start_lit | src_mask[SLICE_BYTES-1])
	                                     : (lit_mode & src_mask[SLICE_BYTES-1]);
	assign shamt      = keep_head ? 5'd0 : next_dist;
	assign shift_data = src_data << {shamt, 3'b000};  // one shifter for load and cut
	assign shift_mask = src_mask << shamt;

	assign head_tag = buf_data[BUF_BYTES-1];

	tag_decode u_dec (
		.tag_i       (head_tag),
		.next_i      ({buf_data[BUF_BYTES-2], buf_data[BUF_BYTES-3]}),
		.kind_o      (kind),
		.hdr_bytes_o (hdr_bytes),
		.lit_len_o   (lit_len),
		.copy_len_o  (copy_len),
		.copy_off_o  (copy_off)
	);

	assign copy_adv = {copy_len == 6'd0, copy_len};

	// literal body starts after the header unless the slice opened inside it
	assign body_off   = lit_mode ? 2'd0 : hdr_bytes;
	assign body_shift = buf_data << {body_off, 3'b000};
	assign lit_src    = body_shift[BUF_BYTES-1 -: SLICE_BYTES];
	assign avail      = (shamt > {3'b000, body_off}) ? shamt - {3'b000, body_off} : 5'd0;

	always_comb begin
		if (!lit_mode && ({1'b0, avail} > lit_len))
			lit_cnt = lit_len[4:0];
		else
			lit_cnt = avail;
		for (int i = 0; i < SLICE_BYTES; i++) begin
			lit_bytes[SLICE_BYTES-1-i] = (5'(i) < lit_cnt) ? lit_src[SLICE_BYTES-1-i] : 8'h00;
		end
	end

	assign cut_go    = (state == S_CUT) & ~stall_i;
	assign head_ok   = (buf_rem != 5'd0);
	assign emit_lit  = cut_go & head_ok & (lit_mode | (kind == LIT)) & (lit_cnt != 5'd0);
	assign emit_copy = cut_go & head_ok & ~lit_mode & ((kind == COPY1) | (kind == COPY2));
	assign done      = ~head_ok | (~keep_head & ~lzc_any);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state       <= S_IDLE;
			lit_mode    <= 1'b0;
			out_addr    <= '0;
			lit_push_o  <= 1'b0;
			copy_push_o <= 1'b0;
		end else begin
			lit_push_o  <= emit_lit;
			copy_push_o <= emit_copy;
			case (state)
				S_IDLE: state <= S_WAIT;
				S_WAIT: begin
					if (slice_valid_i) begin
						lit_mode <= slice_i.start_lit;
						state    <= S_CUT;
					end
				end
				S_CUT: begin
					if (!stall_i) begin
						lit_mode <= 1'b0;
						if (emit_lit)
							out_addr <= out_addr + ADDR_W'(lit_cnt);
						else if (emit_copy)
							out_addr <= out_addr + ADDR_W'(copy_adv);
						if (done)
							state <= S_WAIT;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (((state == S_WAIT) && slice_valid_i) || cut_go) begin
			buf_data <= shift_data;
			buf_mask <= shift_mask;
			buf_rem  <= src_rem - shamt;
		end
		if (emit_lit)
			lit_desc_o <= '{addr: out_addr, count: lit_cnt, bytes: lit_bytes};
		if (emit_copy)
			copy_desc_o <= '{addr: out_addr, offset: copy_off, length: copy_len};
	end

	assign slice_ready_o = (state == S_WAIT);
	assign idle_o        = (state == S_WAIT) & ~lit_push_o & ~copy_push_o;

endmodule

/* hdl/tag_decode.sv */
// decodes the snappy tag at the head of the slice buffer
// next_i carries the two bytes after the tag, nearest byte in the top half
// tag 11 comes back as BAD with a one-byte header
// lit_len_o wraps for the long literal headers, which are not supported
`timescale 1ns/100ps

module tag_decode (
	input  snappy_pkg::tag_u      tag_i,
	input  logic [15:0]           next_i,
	output snappy_pkg::tok_kind_e kind_o,
	output logic [1:0]            hdr_bytes_o,
	output logic [5:0]            lit_len_o,
	output logic [5:0]            copy_len_o,
	output logic [15:0]           copy_off_o
);

	import snappy_pkg::*;

	logic [7:0] byte1;
	logic [7:0] byte2;

	assign byte1 = next_i[15:8];
	assign byte2 = next_i[7:0];

	always_comb begin
		kind_o      = tok_kind_e'(tag_i.lit.kind);
		hdr_bytes_o = 2'd1;
		lit_len_o   = tag_i.lit.len_m1 + 6'd1;
		copy_len_o  = '0;
		copy_off_o  = '0;

		case (kind_o)
			COPY1: begin
				hdr_bytes_o = 2'd2;
				copy_len_o  = 6'd4 + {3'b000, tag_i.copy.len_f};
				copy_off_o  = {5'b00000, tag_i.copy.off_hi, byte1};
			end
			COPY2: begin
				// same six-bit length layout as a literal header
				hdr_bytes_o = 2'd3;
				copy_len_o  = tag_i.lit.len_m1 + 6'd1;  // 64 wraps to 0
				copy_off_o  = {byte2, byte1};         // little endian
			end
			default: begin
				// literal or unsupported tag keep the one-byte header
				hdr_bytes_o = 2'd1;
			end
		endcase
	end

endmodule

/* hdl/lead_zero_count.sv */
// leading zero count of a 16-bit token mask, bit 15 counted first
// zeros_o is only meaningful while any_o is high
`timescale 1ns/100ps

module lead_zero_count (
	input  logic [15:0] mask_i,
	output logic        any_o,
	output logic [3:0]  zeros_o
);

	logic [3:0]      grp_any;
	logic [3:0][1:0] grp_zeros;  // group 3 holds bits 15..12
	logic [1:0]      top_zeros;

	// returns {any, leading zeros} of one nibble
	function automatic logic [2:0] penc4(input logic [3:0] x);
		logic [1:0] z;
		if (x[3])
			z = 2'd0;
		else if (x[2])
			z = 2'd1;
		else if (x[1])
			z = 2'd2;
		else
			z = 2'd3;
		return {|x, z};
	endfunction

	always_comb begin
		for (int g = 0; g < 4; g++) begin
			{grp_any[g], grp_zeros[g]} = penc4(mask_i[4*g +: 4]);
		end
		{any_o, top_zeros} = penc4(grp_any);  // second level picks the first busy nibble
		zeros_o = {top_zeros, grp_zeros[2'd3 - top_zeros]};
	end

endmodule

/* hdl/snappy_pkg.sv */
// shared types and stream constants of the snappy token parser
// slice bytes are packed with byte 0 in the top byte lane
// lookahead bytes follow byte 15 in the two lowest lanes
// a 64-byte copy shows length 0 in the 6-bit descriptor field
// only one-byte literal headers are understood (lengths 1 to 60)
package snappy_pkg;

	localparam int SLICE_BYTES = 16;
	localparam int LOOK_BYTES  = 2;
	localparam int BUF_BYTES   = SLICE_BYTES + LOOK_BYTES;
	localparam int ADDR_W      = 16;

	// one slice as delivered by the stream splitter
	typedef struct packed {
		logic [BUF_BYTES-1:0][7:0] data;        // byte 0 at index BUF_BYTES-1
		logic [SLICE_BYTES-1:0]    token_mask;  // bit 15 marks byte 0
		logic                      start_lit;   // slice opens inside a literal body
	} slice_t;

	// literal header view
	typedef struct packed {
		logic [5:0] len_m1;  // body length minus one
		logic [1:0] kind;
	} tag_lit_t;

	// one-byte-offset copy view
	typedef struct packed {
		logic [2:0] off_hi;  // offset bits 10..8
		logic [2:0] len_f;   // length minus four
		logic [1:0] kind;
	} tag_copy_t;

	typedef union packed {
		tag_lit_t  lit;
		tag_copy_t copy;
	} tag_u;

	typedef enum logic [1:0] {
		LIT   = 2'b00,
		COPY1 = 2'b01,
		COPY2 = 2'b10,
		BAD   = 2'b11
	} tok_kind_e;

	typedef struct packed {
		logic [ADDR_W-1:0]           addr;   // output address of the first byte
		logic [4:0]                  count;  // 1 to 16
		logic [SLICE_BYTES-1:0][7:0] bytes;  // left aligned, unused lanes zero
	} lit_desc_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [15:0]       offset;
		logic [5:0]        length;
	} copy_desc_t;

endpackage
